// ==== sim/mipsStimulus.txt ====
# P byteAddress word : program word, E test pc reg value : expected write, in order
# addresses, words, pc and value in hex, test and reg in decimal
P 000 20010005 E 1 000 1 00000005
P 004 2002FFFD E 1 004 2 FFFFFFFD
P 008 00221820 E 1 008 3 00000002
P 00C 00222022 E 1 00C 4 00000008
P 010 00222824 E 1 010 5 00000005
P 014 00223025 E 1 014 6 FFFFFFFD
P 018 00223826 E 1 018 7 FFFFFFF8
P 01C 00224027 E 1 01C 8 00000002
P 020 0041482A E 1 020 9 00000001
P 024 0022502A E 1 024 10 00000000
P 028 30CB00F0 E 2 028 11 000000F0
P 02C 342C0130 E 2 02C 12 00000135
P 030 382D00FF E 2 030 13 000000FA
P 034 284EFFFE E 2 034 14 00000001
P 038 00017D00 E 2 038 15 00500000
P 03C 00028702 E 2 03C 16 0000000F
P 040 70CF8802 E 2 040 17 FF100000
P 044 AC110100 P 048 A4060100 P 04C A00D0101
P 050 8C130100 E 3 050 19 FF10FAFD
P 054 84140100 E 3 054 20 FFFFFAFD
P 058 80150101 E 3 058 21 FFFFFFFA
P 05C 80160102 E 3 05C 22 00000010
P 060 84170102 E 3 060 23 FFFFFF10
P 064 10250001 P 068 20180099
P 06C 14220001 P 070 20180098
P 074 10220001 P 078 20180011 E 4 078 24 00000011
P 07C 14250001 P 080 20190022 E 4 080 25 00000022
P 084 0C000028 E 5 084 31 00000088
P 088 0800002C P 08C 201A0055
P 0A0 201A0033 E 5 0A0 26 00000033
P 0A4 03E00008
P 0B0 201B0044 E 5 0B0 27 00000044
P 0B4 FC1C0077 P 0B8 201C0066 E 6 0B8 28 00000066
P 0BC 0800002F

// ==== sim.f ====
source/mipsIsaPkg.sv
source/mipsCtrlPkg.sv
source/Controller.sv
source/RegisterFile.sv
source/ALU.sv
source/DataMemory.sv
source/NextPcUnit.sv
source/MipsCore.sv
sim/mipsCore_sva.sv
sim/tbMipsCore.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tbMipsCore -f sim.f -o simMipsCore \
        && ./obj_dir/simMipsCore > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim/tbMipsCore.sv ====
`timescale 1ns/10ps

module tbMipsCore;

        localparam int    CLK_PERIOD   = 40;
        localparam int    DRIVE_DELAY  = 2;
        localparam int    RESET_CYCLES = 5;
        localparam int    MEM_WORDS    = 256;
        localparam string STIM_FILE    = "sim/mipsStimulus.txt";

        // one expected register write
        typedef struct packed {
                logic [7:0]  test;
                logic [31:0] pc;
                logic [4:0]  regNum;
                logic [31:0] value;
        } expWrite_t;

        logic                     clk;
        logic                     reset;
        mipsIsaPkg::instruction_t instruction;
        logic [31:0]              pc;
        logic                     regWriteEn;
        logic [4:0]               regWriteAddr;
        logic [31:0]              regWriteData;

        logic [31:0] progMem [MEM_WORDS];
        expWrite_t   expectQ [$];
        int          testErrors [256] = '{default: 0};
        int          progWords = 0;
        int          errorCount = 0;
        int          testsRun = 0;
        int          testsFailed = 0;
        logic        stimOk = 1'b1;
        logic        loaded = 1'b0;
        logic        programDone = 1'b0;

        MipsCore #(
                .DATA_MEM_BYTES(1024),
                .RESET_PC      (32'd0)
        ) u_dut (
                .clk         (clk),
                .reset       (reset),
                .instruction (instruction),
                .pc          (pc),
                .regWriteEn  (regWriteEn),
                .regWriteAddr(regWriteAddr),
                .regWriteData(regWriteData)
        );

        //////////////////////////////////////////////////////////////////////
        // stimulus file and checks
        //////////////////////////////////////////////////////////////////////
        task automatic loadStimulus();
                int          fd;
                int          n;
                int          i;
                int          testNum;
                int          regNum;
                string       tag;
                string       rest;
                logic [31:0] addr;
                logic [31:0] word;
                logic [31:0] pcVal;
                logic [31:0] value;
                expWrite_t   entry;
                for (i = 0; i < MEM_WORDS; i++)
                        progMem[i] = 32'd0;
                fd = $fopen(STIM_FILE, "r");
                if (fd == 0) begin
                        $display("could not open stimulus file %s", STIM_FILE);
                        stimOk = 1'b0;
                end else begin
                        while ($fscanf(fd, "%s", tag) == 1) begin
                                if (tag == "P") begin
                                        n = $fscanf(fd, "%h %h", addr, word);
                                        progMem[addr[9:2]] = word;
                                        progWords++;
                                end else if (tag == "E") begin
                                        n = $fscanf(fd, "%d %h %d %h",
                                                    testNum, pcVal, regNum, value);
                                        entry.test   = testNum[7:0];
                                        entry.pc     = pcVal;
                                        entry.regNum = regNum[4:0];
                                        entry.value  = value;
                                        expectQ.push_back(entry);
                                end else begin
                                        // skip a comment line
                                        n = $fgets(rest, fd);
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task automatic checkWrite();
                expWrite_t exp;
                if (expectQ.size() == 0) begin
                        $display("no write was expected, but register %0d got %h at pc %h",
                                 regWriteAddr, regWriteData, pc);
                        errorCount++;
                end else begin
                        exp = expectQ.pop_front();
                        assert (pc == exp.pc) else begin
                                $display("FAIL %0t: test %0d pc expected %h, got %h",
                                         $time, exp.test, exp.pc, pc);
                                testErrors[exp.test]++;
                                errorCount++;
                        end
                        assert (regWriteAddr == exp.regNum) else begin
                                $display("FAIL %0t: test %0d write address expected %0d, got %0d",
                                         $time, exp.test, exp.regNum, regWriteAddr);
                                testErrors[exp.test]++;
                                errorCount++;
                        end
                        assert (regWriteData == exp.value) else begin
                                $display("FAIL %0t: test %0d write data expected %h, got %h",
                                         $time, exp.test, exp.value, regWriteData);
                                testErrors[exp.test]++;
                                errorCount++;
                        end
                        // last write of this test
                        if (expectQ.size() == 0 || expectQ[0].test != exp.test) begin
                                testsRun++;
                                if (testErrors[exp.test] != 0)
                                        testsFailed++;
                                $display("test %0d finished with %0d errors",
                                         exp.test, testErrors[exp.test]);
                        end
                end
        endtask

        // j whose target is its own address ends the program
        function automatic logic isSelfJump(mipsIsaPkg::instruction_t instr, logic [31:0] addr);
                logic [31:0] nextAddr;
                logic [31:0] target;
                nextAddr = addr + 32'd4;
                target   = {nextAddr[31:28], instr.j.target26, 2'b00};
                return instr.j.opcode == mipsIsaPkg::OP_J && target == addr;
        endfunction

        //////////////////////////////////////////////////////////////////////
        // processes
        //////////////////////////////////////////////////////////////////////
        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        // instruction memory answers pc
        initial begin
                instruction = '0;
                forever begin
                        @(posedge clk);
                        #DRIVE_DELAY;
                        instruction = progMem[pc[9:2]];
                end
        end

        // sample 1 ns before the rising edge
        always @(negedge clk) begin
                #(CLK_PERIOD / 2 - 1);
                if (!reset && regWriteEn)
                        checkWrite();
                if (!reset && isSelfJump(instruction, pc))
                        programDone = 1'b1;
        end

        initial begin
                reset = 1'b1;
                loadStimulus();
                loaded = 1'b1;
                repeat (RESET_CYCLES) @(posedge clk);
                #DRIVE_DELAY;
                reset = 1'b0;
                wait (programDone || !stimOk);
                if (expectQ.size() != 0)
                        $display("%0d expected register writes never happened", expectQ.size());
                $display("tests run %0d, tests failed %0d, check errors %0d",
                         testsRun, testsFailed, errorCount);
                if (stimOk && errorCount == 0 && expectQ.size() == 0)
                        $display("TEST PASS");
                else
                        $display("TEST FAIL");
                $finish;
        end

        // watchdog
        initial begin
                wait (loaded);
                #((progWords + 20) * CLK_PERIOD);
                $display("timeout, the program never reached its closing jump");
                $display("TEST FAIL");
                $finish;
        end

endmodule

// ==== sim/mipsCore_sva.sv ====
`timescale 1ns/10ps

module mipsCoreSva (
        input logic                      clk,
        input logic                      reset,
        input logic                      regWriteEn,
        input logic [31:0]               pc,
        input mipsCtrlPkg::ctrlSignals_t ctrl
);

        // no register write leaks out while reset is held
        assert property (@(posedge clk) reset |-> !regWriteEn)
                else $error("regWriteEn is high during reset");

        // a store never writes a register
        assert property (@(posedge clk) disable iff (reset)
                !(ctrl.regWrite && ctrl.memWrite != mipsCtrlPkg::MEM_NONE))
                else $error("store decoded together with a register write");

        assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
                else $error("pc %h is not word aligned", pc);

endmodule

bind MipsCore mipsCoreSva u_sva (
        .clk       (clk),
        .reset     (reset),
        .regWriteEn(regWriteEn),
        .pc        (pc),
        .ctrl      (ctrl)
);

// ==== source/MipsCore.sv ====
`timescale 1ns/10ps

module MipsCore #(
        parameter int          DATA_MEM_BYTES = 1024,
        parameter logic [31:0] RESET_PC       = 32'd0
) (
        input  logic                     clk,
        input  logic                     reset,
        input  mipsIsaPkg::instruction_t instruction,
        output logic [31:0]              pc,
        output logic                     regWriteEn,
        output logic [4:0]               regWriteAddr,
        output logic [31:0]              regWriteData
);

        mipsCtrlPkg::ctrlSignals_t ctrl;
        mipsCtrlPkg::memSize_t     memWriteGated;

        logic        branchOutput;
        logic [31:0] pcPlus4;
        logic [31:0] readDataA;
        logic [31:0] readDataB;
        logic [31:0] immExt;
        logic [31:0] operandB;
        logic [4:0]  shiftAmount;
        logic [31:0] aluResult;
        logic [31:0] loadData;

        //////////////////////////////////////////////////////////////////////
        // fetch and decode
        //////////////////////////////////////////////////////////////////////
        NextPcUnit #(.RESET_PC(RESET_PC)) u_nextPc (
                .clk         (clk),
                .reset       (reset),
                .instruction (instruction),
                .readDataA   (readDataA),
                .readDataB   (readDataB),
                .pcSrc       (ctrl.pcSrc),
                .jump        (ctrl.jump),
                .jr          (ctrl.jr),
                .pc          (pc),
                .pcPlus4     (pcPlus4),
                .branchOutput(branchOutput)
        );

        Controller u_controller (
                .instruction (instruction),
                .branchOutput(branchOutput),
                .ctrl        (ctrl)
        );

        RegisterFile u_regFile (
                .clk      (clk),
                .reset    (reset),
                .writeEn  (regWriteEn),
                .writeAddr(regWriteAddr),
                .writeData(regWriteData),
                .readAddrA(instruction.r.rs),
                .readAddrB(instruction.r.rt),
                .readDataA(readDataA),
                .readDataB(readDataB)
        );

        //////////////////////////////////////////////////////////////////////
        // execute and memory
        //////////////////////////////////////////////////////////////////////
        assign immExt   = {{16{instruction.i.imm16[15]}}, instruction.i.imm16};
        assign operandB = ctrl.aluSrc ? immExt : readDataB;
        // shamt only matters for sll and srl
        assign shiftAmount = ctrl.shiftControl ? instruction.r.shamt : 5'd0;

        ALU u_alu (
                .aluControl(ctrl.aluControl),
                .operandA  (readDataA),
                .operandB  (operandB),
                .shamt     (shiftAmount),
                .result    (aluResult)
        );

        assign memWriteGated = reset ? mipsCtrlPkg::MEM_NONE : ctrl.memWrite;

        DataMemory #(.DATA_MEM_BYTES(DATA_MEM_BYTES)) u_dataMem (
                .clk      (clk),
                .reset    (reset),
                .address  (aluResult),
                .writeData(readDataB),
                .memWrite (memWriteGated),
                .memRead  (ctrl.memRead),
                .loadData (loadData)
        );

        // writeback
        assign regWriteEn = ctrl.regWrite & ~reset;

        always_comb begin
                if (ctrl.jal)
                        regWriteAddr = mipsIsaPkg::REG_RA;
                else if (ctrl.regDst)
                        regWriteAddr = instruction.r.rd;
                else
                        regWriteAddr = instruction.r.rt;
        end

        always_comb begin
                if (ctrl.jal)
                        regWriteData = pcPlus4;
                else if (ctrl.memToReg)
                        regWriteData = aluResult;
                else
                        regWriteData = loadData;
        end

endmodule

// ==== source/NextPcUnit.sv ====
`timescale 1ns/10ps

module NextPcUnit #(
        parameter logic [31:0] RESET_PC = 32'd0
) (
        input  logic                     clk,
        input  logic                     reset,
        input  mipsIsaPkg::instruction_t instruction,
        input  logic [31:0]              readDataA,
        input  logic [31:0]              readDataB,
        input  logic                     pcSrc,
        input  logic                     jump,
        input  logic                     jr,
        output logic [31:0]              pc,
        output logic [31:0]              pcPlus4,
        output logic                     branchOutput
);

        logic [31:0] branchOffset;
        logic [31:0] nextPc;

        assign pcPlus4 = pc + 32'd4;

        // opcode bit 0 set means bne
        assign branchOutput = instruction.i.opcode[0] ? (readDataA != readDataB)
                                                      : (readDataA == readDataB);

        assign branchOffset = {{14{instruction.i.imm16[15]}}, instruction.i.imm16, 2'b00};

        always_comb begin
                if (jr)
                        nextPc = readDataA;
                else if (jump)
                        nextPc = {pcPlus4[31:28], instruction.j.target26, 2'b00};
                else if (pcSrc)
                        nextPc = pcPlus4 + branchOffset;
                else
                        nextPc = pcPlus4;
        end

        always_ff @(posedge clk) begin
                if (reset)
                        pc <= RESET_PC;
                else
                        pc <= nextPc;
        end

endmodule

// ==== source/DataMemory.sv ====
`timescale 1ns/10ps

module DataMemory #(
        parameter int DATA_MEM_BYTES = 1024
) (
        input  logic                  clk,
        input  logic                  reset,
        input  logic [31:0]           address,
        input  logic [31:0]           writeData,
        input  mipsCtrlPkg::memSize_t memWrite,
        input  mipsCtrlPkg::memSize_t memRead,
        output logic [31:0]           loadData
);

        localparam int ADDR_BITS = $clog2(DATA_MEM_BYTES);

        logic [7:0] mem [DATA_MEM_BYTES];

        // byte lanes, wrap at the memory size
        logic [ADDR_BITS-1:0] byteAddr0;
        logic [ADDR_BITS-1:0] byteAddr1;
        logic [ADDR_BITS-1:0] byteAddr2;
        logic [ADDR_BITS-1:0] byteAddr3;
        logic [31:0]          wordData;

        assign byteAddr0 = address[ADDR_BITS-1:0];
        assign byteAddr1 = byteAddr0 + 1'b1;
        assign byteAddr2 = byteAddr0 + 2'd2;
        assign byteAddr3 = byteAddr0 + 2'd3;

        // little endian, lowest address holds bits 7:0
        assign wordData = {mem[byteAddr3], mem[byteAddr2], mem[byteAddr1], mem[byteAddr0]};

        always_ff @(posedge clk) begin
                if (!reset) begin
                        case (memWrite)
                        mipsCtrlPkg::MEM_WORD: begin
                                mem[byteAddr0] <= writeData[7:0];
                                mem[byteAddr1] <= writeData[15:8];
                                mem[byteAddr2] <= writeData[23:16];
                                mem[byteAddr3] <= writeData[31:24];
                        end
                        mipsCtrlPkg::MEM_HALF: begin
                                mem[byteAddr0] <= writeData[7:0];
                                mem[byteAddr1] <= writeData[15:8];
                        end
                        mipsCtrlPkg::MEM_BYTE: mem[byteAddr0] <= writeData[7:0];
                        default: ;
                        endcase
                end
        end

        always_comb begin
                case (memRead)
                mipsCtrlPkg::MEM_WORD: loadData = wordData;
                mipsCtrlPkg::MEM_HALF: loadData = {{16{wordData[15]}}, wordData[15:0]};
                mipsCtrlPkg::MEM_BYTE: loadData = {{24{wordData[7]}}, wordData[7:0]};
                default:               loadData = 32'd0;
                endcase
        end

endmodule

// ==== source/ALU.sv ====
`timescale 1ns/10ps

module ALU (
        input  mipsCtrlPkg::aluOp_t aluControl,
        input  logic [31:0]         operandA,
        input  logic [31:0]         operandB,
        input  logic [4:0]          shamt,
        output logic [31:0]         result
);

        always_comb begin
                case (aluControl)
                mipsCtrlPkg::ALU_ADD: result = operandA + operandB;
                mipsCtrlPkg::ALU_SUB: result = operandA - operandB;
                // low half of the product only
                mipsCtrlPkg::ALU_MUL: result = operandA * operandB;
                mipsCtrlPkg::ALU_SLL: result = operandB << shamt;
                mipsCtrlPkg::ALU_SRL: result = operandB >> shamt;
                mipsCtrlPkg::ALU_AND: result = operandA & operandB;
                mipsCtrlPkg::ALU_OR:  result = operandA | operandB;
                mipsCtrlPkg::ALU_XOR: result = operandA ^ operandB;
                mipsCtrlPkg::ALU_NOR: result = ~(operandA | operandB);
                mipsCtrlPkg::ALU_SLT: begin
                        result = ($signed(operandA) < $signed(operandB)) ? 32'd1 : 32'd0;
                end
                default:              result = 32'd0;
                endcase
        end

endmodule

// ==== source/RegisterFile.sv ====
`timescale 1ns/10ps

module RegisterFile (
        input  logic        clk,
        input  logic        reset,
        input  logic        writeEn,
        input  logic [4:0]  writeAddr,
        input  logic [31:0] writeData,
        input  logic [4:0]  readAddrA,
        input  logic [4:0]  readAddrB,
        output logic [31:0] readDataA,
        output logic [31:0] readDataB
);

        logic [31:0] regs [32];

        always_ff @(posedge clk) begin
                if (!reset && writeEn && writeAddr != 5'd0) begin
                        regs[writeAddr] <= writeData;
                end
        end

        // $0 reads as zero whatever the array holds
        assign readDataA = (readAddrA == 5'd0) ? 32'd0 : regs[readAddrA];
        assign readDataB = (readAddrB == 5'd0) ? 32'd0 : regs[readAddrB];

endmodule

// ==== source/Controller.sv ====
`timescale 1ns/10ps

module Controller (
        input  mipsIsaPkg::instruction_t  instruction,
        input  logic                      branchOutput,
        output mipsCtrlPkg::ctrlSignals_t ctrl
);

        always_comb begin
                // no-op values, overridden per opcode
                ctrl            = '0;
                ctrl.aluControl = mipsCtrlPkg::ALU_NONE;

                case (instruction.r.opcode)
                mipsIsaPkg::OP_RTYPE: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.memToReg = 1'b1;
                        case (instruction.r.funct)
                        mipsIsaPkg::FN_JR: begin
                                ctrl.regWrite = 1'b0;
                                ctrl.memToReg = 1'b0;
                                ctrl.jr       = 1'b1;
                        end
                        mipsIsaPkg::FN_SLL: begin
                                ctrl.aluControl   = mipsCtrlPkg::ALU_SLL;
                                ctrl.shiftControl = 1'b1;
                        end
                        mipsIsaPkg::FN_SRL: begin
                                ctrl.aluControl   = mipsCtrlPkg::ALU_SRL;
                                ctrl.shiftControl = 1'b1;
                        end
                        mipsIsaPkg::FN_ADD: ctrl.aluControl = mipsCtrlPkg::ALU_ADD;
                        mipsIsaPkg::FN_SUB: ctrl.aluControl = mipsCtrlPkg::ALU_SUB;
                        mipsIsaPkg::FN_AND: ctrl.aluControl = mipsCtrlPkg::ALU_AND;
                        mipsIsaPkg::FN_OR:  ctrl.aluControl = mipsCtrlPkg::ALU_OR;
                        mipsIsaPkg::FN_XOR: ctrl.aluControl = mipsCtrlPkg::ALU_XOR;
                        mipsIsaPkg::FN_NOR: ctrl.aluControl = mipsCtrlPkg::ALU_NOR;
                        mipsIsaPkg::FN_SLT: ctrl.aluControl = mipsCtrlPkg::ALU_SLT;
                        // unknown funct behaves as a no-op
                        default: begin
                                ctrl.regWrite = 1'b0;
                                ctrl.regDst   = 1'b0;
                                ctrl.memToReg = 1'b0;
                        end
                        endcase
                end
                mipsIsaPkg::OP_MUL: begin
                        ctrl.regWrite   = 1'b1;
                        ctrl.regDst     = 1'b1;
                        ctrl.memToReg   = 1'b1;
                        ctrl.aluControl = mipsCtrlPkg::ALU_MUL;
                end

                //////////////////////////////////////////////////////////////
                // loads and stores, address is rs + imm
                //////////////////////////////////////////////////////////////
                mipsIsaPkg::OP_LW, mipsIsaPkg::OP_LH, mipsIsaPkg::OP_LB: begin
                        ctrl.regWrite   = 1'b1;
                        ctrl.aluSrc     = 1'b1;
                        ctrl.aluControl = mipsCtrlPkg::ALU_ADD;
                        if (instruction.r.opcode == mipsIsaPkg::OP_LW)
                                ctrl.memRead = mipsCtrlPkg::MEM_WORD;
                        else if (instruction.r.opcode == mipsIsaPkg::OP_LH)
                                ctrl.memRead = mipsCtrlPkg::MEM_HALF;
                        else
                                ctrl.memRead = mipsCtrlPkg::MEM_BYTE;
                end
                mipsIsaPkg::OP_SW, mipsIsaPkg::OP_SH, mipsIsaPkg::OP_SB: begin
                        ctrl.aluSrc     = 1'b1;
                        ctrl.aluControl = mipsCtrlPkg::ALU_ADD;
                        if (instruction.r.opcode == mipsIsaPkg::OP_SW)
                                ctrl.memWrite = mipsCtrlPkg::MEM_WORD;
                        else if (instruction.r.opcode == mipsIsaPkg::OP_SH)
                                ctrl.memWrite = mipsCtrlPkg::MEM_HALF;
                        else
                                ctrl.memWrite = mipsCtrlPkg::MEM_BYTE;
                end

                //////////////////////////////////////////////////////////////
                // immediates
                //////////////////////////////////////////////////////////////
                mipsIsaPkg::OP_ADDI, mipsIsaPkg::OP_ANDI, mipsIsaPkg::OP_ORI,
                mipsIsaPkg::OP_XORI, mipsIsaPkg::OP_SLTI: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluSrc   = 1'b1;
                        ctrl.memToReg = 1'b1;
                        case (instruction.r.opcode)
                        mipsIsaPkg::OP_ANDI: ctrl.aluControl = mipsCtrlPkg::ALU_AND;
                        mipsIsaPkg::OP_ORI:  ctrl.aluControl = mipsCtrlPkg::ALU_OR;
                        mipsIsaPkg::OP_XORI: ctrl.aluControl = mipsCtrlPkg::ALU_XOR;
                        mipsIsaPkg::OP_SLTI: ctrl.aluControl = mipsCtrlPkg::ALU_SLT;
                        default:             ctrl.aluControl = mipsCtrlPkg::ALU_ADD;
                        endcase
                end

                // taken or not comes from the compare in NextPcUnit
                mipsIsaPkg::OP_BEQ, mipsIsaPkg::OP_BNE: ctrl.pcSrc = branchOutput;
                mipsIsaPkg::OP_J: ctrl.jump = 1'b1;
                mipsIsaPkg::OP_JAL: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.jump     = 1'b1;
                        ctrl.jal      = 1'b1;
                end
                default: ;
                endcase
        end

endmodule

// ==== source/mipsCtrlPkg.sv ====
package mipsCtrlPkg;

        // ALU codes as used by the decoder
        typedef enum logic [4:0] {
                ALU_ADD  = 5'd1,
                ALU_SUB  = 5'd2,
                ALU_MUL  = 5'd3,
                ALU_SLL  = 5'd4,
                ALU_SRL  = 5'd5,
                ALU_AND  = 5'd6,
                ALU_OR   = 5'd7,
                ALU_XOR  = 5'd8,
                ALU_NOR  = 5'd13,
                ALU_SLT  = 5'd14,
                ALU_NONE = 5'd31
        } aluOp_t;

        // access width for loads and stores, 0 means no access
        typedef enum logic [1:0] {
                MEM_NONE = 2'd0,
                MEM_WORD = 2'd1,
                MEM_HALF = 2'd2,
                MEM_BYTE = 2'd3
        } memSize_t;

        typedef struct packed {
                logic     regWrite;
                logic     aluSrc;
                logic     regDst;
                logic     memToReg;     // 1 picks the ALU result
                logic     jump;
                logic     jr;
                logic     jal;
                logic     shiftControl;
                logic     pcSrc;
                aluOp_t   aluControl;
                memSize_t memWrite;
                memSize_t memRead;
        } ctrlSignals_t;

endpackage

// ==== source/mipsIsaPkg.sv ====
package mipsIsaPkg;

        //////////////////////////////////////////////////////////////////////
        // opcodes
        //////////////////////////////////////////////////////////////////////
        localparam logic [5:0] OP_RTYPE = 6'b000000;
        localparam logic [5:0] OP_MUL   = 6'b011100;
        localparam logic [5:0] OP_LW    = 6'b100011;
        localparam logic [5:0] OP_LH    = 6'b100001;
        localparam logic [5:0] OP_LB    = 6'b100000;
        localparam logic [5:0] OP_SW    = 6'b101011;
        localparam logic [5:0] OP_SH    = 6'b101001;
        localparam logic [5:0] OP_SB    = 6'b101000;
        localparam logic [5:0] OP_ADDI  = 6'b001000;
        localparam logic [5:0] OP_ANDI  = 6'b001100;
        localparam logic [5:0] OP_ORI   = 6'b001101;
        localparam logic [5:0] OP_XORI  = 6'b001110;
        localparam logic [5:0] OP_SLTI  = 6'b001010;
        // beq and bne differ only in bit 0
        localparam logic [5:0] OP_BEQ   = 6'b000100;
        localparam logic [5:0] OP_BNE   = 6'b000101;
        localparam logic [5:0] OP_J     = 6'b000010;
        localparam logic [5:0] OP_JAL   = 6'b000011;

        // function codes of the R-type group
        localparam logic [5:0] FN_SLL = 6'b000000;
        localparam logic [5:0] FN_SRL = 6'b000010;
        localparam logic [5:0] FN_JR  = 6'b001000;
        localparam logic [5:0] FN_ADD = 6'b100000;
        localparam logic [5:0] FN_SUB = 6'b100010;
        localparam logic [5:0] FN_AND = 6'b100100;
        localparam logic [5:0] FN_OR  = 6'b100101;
        localparam logic [5:0] FN_XOR = 6'b100110;
        localparam logic [5:0] FN_NOR = 6'b100111;
        localparam logic [5:0] FN_SLT = 6'b101010;

        // link register for jal
        localparam logic [4:0] REG_RA = 5'd31;

        //////////////////////////////////////////////////////////////////////
        // instruction formats
        //////////////////////////////////////////////////////////////////////
        typedef struct packed {
                logic [5:0] opcode;
                logic [4:0] rs;
                logic [4:0] rt;
                logic [4:0] rd;
                logic [4:0] shamt;
                logic [5:0] funct;
        } rFormat_t;

        typedef struct packed {
                logic [5:0]  opcode;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [15:0] imm16;
        } iFormat_t;

        typedef struct packed {
                logic [5:0]  opcode;
                logic [25:0] target26;
        } jFormat_t;

        // same word, three views
        typedef union packed {
                rFormat_t r;
                iFormat_t i;
                jFormat_t j;
        } instruction_t;

endpackage
